// File: src/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

  // widest pointer the conversion functions accept, wrap bit included
  parameter int AFIFO_PTR_MAX_W = 16;

  parameter int AFIFO_DEF_DATA_W = 8;
  parameter int AFIFO_DEF_DEPTH  = 16;

  function automatic logic [AFIFO_PTR_MAX_W-1:0] bin2gray(
    input logic [AFIFO_PTR_MAX_W-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [AFIFO_PTR_MAX_W-1:0] gray2bin(
    input logic [AFIFO_PTR_MAX_W-1:0] gray
  );
    logic [AFIFO_PTR_MAX_W-1:0] bin;
    bin[AFIFO_PTR_MAX_W-1] = gray[AFIFO_PTR_MAX_W-1];
    for (int i = AFIFO_PTR_MAX_W-2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // each binary bit folds in all gray bits above it
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// File: src/afifo_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface afifo_ram_if #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
);

  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;  // driven from the top-level port

  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;

  modport wr_side (
    output wr_en,
    output wr_addr
  );

  modport rd_side (
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

// File: src/afifo_dpram.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_dpram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  wire            wr_clk,
  input  wire            rd_clk,
  afifo_ram_if.mem       ram
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem_array [0:DEPTH-1];

  // write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem_array[ram.wr_addr] <= ram.wr_data;
    end
  end

  // registered read port, rd_data holds its value between pops
  always_ff @(posedge rd_clk) begin
    if (ram.rd_en) begin
      ram.rd_data <= mem_array[ram.rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/afifo_gray_sync.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_gray_sync
  import afifo_pkg::*;
#(
  parameter int PTR_W = 5
) (
  input  wire              dst_clk,
  input  wire              dst_rst_n,
  input  wire  [PTR_W-1:0] ptr_gray,
  output logic [PTR_W-1:0] ptr_bin
);

  logic [PTR_W-1:0]           ptr_gray_meta;  // first stage, may go metastable
  logic [PTR_W-1:0]           ptr_gray_sync;
  logic [AFIFO_PTR_MAX_W-1:0] ptr_bin_full;

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      ptr_gray_meta <= '0;
      ptr_gray_sync <= '0;
    end else begin
      ptr_gray_meta <= ptr_gray;
      ptr_gray_sync <= ptr_gray_meta;
    end
  end

  // only one bit moves per source update, so the sampled code is either the old or new pointer
  assign ptr_bin_full = gray2bin(AFIFO_PTR_MAX_W'(ptr_gray_sync));
  assign ptr_bin      = ptr_bin_full[PTR_W-1:0];

endmodule

`default_nettype wire

// File: src/afifo_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_wr_ctrl
  import afifo_pkg::*;
#(
  parameter int FIFO_DEPTH = 16,
  parameter int FIFO_AFULL = FIFO_DEPTH-1
) (
  input  wire                             wr_clk,
  input  wire                             wr_rst_n,
  input  wire                             wr_en,
  input  wire  [$clog2(FIFO_DEPTH):0]     rd_ptr_bin_wsync,
  afifo_ram_if.wr_side                    ram,
  output logic [$clog2(FIFO_DEPTH):0]     wr_ptr_gray,
  output logic                            full,
  output logic                            afull
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam logic [ADDR_WIDTH:0] AFULL_LVL = (ADDR_WIDTH+1)'(FIFO_AFULL);

  logic                       wr_accept;
  logic [ADDR_WIDTH:0]        wr_ptr;
  logic [ADDR_WIDTH:0]        wr_ptr_nxt;
  logic [AFIFO_PTR_MAX_W-1:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0]        rd_ptr_wrapped;
  logic [ADDR_WIDTH:0]        wr_count_nxt;
  logic                       full_nxt;
  logic                       afull_nxt;

  assign wr_accept = wr_en && !full;  // writes while full are dropped

  always_comb begin
    if (wr_accept) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  assign wr_gray_nxt = bin2gray(AFIFO_PTR_MAX_W'(wr_ptr_nxt));

  // full when the pointers match on address but differ in the wrap bit
  assign rd_ptr_wrapped = {~rd_ptr_bin_wsync[ADDR_WIDTH], rd_ptr_bin_wsync[ADDR_WIDTH-1:0]};
  assign full_nxt       = (wr_ptr_nxt == rd_ptr_wrapped);

  assign wr_count_nxt = wr_ptr_nxt - rd_ptr_bin_wsync;  // overestimates while the read pointer is in flight
  assign afull_nxt    = (wr_count_nxt >= AFULL_LVL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt[ADDR_WIDTH:0];
      full        <= full_nxt;
      afull       <= afull_nxt;
    end
  end

  assign ram.wr_en   = wr_accept;
  assign ram.wr_addr = wr_ptr[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// File: src/afifo_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_rd_ctrl
  import afifo_pkg::*;
#(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AEMPTY = 1
) (
  input  wire                             rd_clk,
  input  wire                             rd_rst_n,
  input  wire                             rd_en,
  input  wire  [$clog2(FIFO_DEPTH):0]     wr_ptr_bin_rsync,
  afifo_ram_if.rd_side                    ram,
  output logic [$clog2(FIFO_DEPTH):0]     rd_ptr_gray,
  output logic [DATA_WIDTH-1:0]           rd_data,
  output logic                            rd_valid,
  output logic                            empty,
  output logic                            aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam logic [ADDR_WIDTH:0] AEMPTY_LVL = (ADDR_WIDTH+1)'(FIFO_AEMPTY);

  logic                       rd_accept;
  logic [ADDR_WIDTH:0]        rd_ptr;
  logic [ADDR_WIDTH:0]        rd_ptr_nxt;
  logic [AFIFO_PTR_MAX_W-1:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0]        rd_count_nxt;
  logic                       empty_nxt;
  logic                       aempty_nxt;

  assign rd_accept = rd_en && !empty;

  always_comb begin
    if (rd_accept) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign rd_gray_nxt = bin2gray(AFIFO_PTR_MAX_W'(rd_ptr_nxt));

  assign empty_nxt    = (rd_ptr_nxt == wr_ptr_bin_rsync);
  assign rd_count_nxt = wr_ptr_bin_rsync - rd_ptr_nxt;  // underestimates while writes are in flight
  assign aempty_nxt   = (rd_count_nxt <= AEMPTY_LVL);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      rd_valid    <= 1'b0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt[ADDR_WIDTH:0];
      rd_valid    <= rd_accept;  // lines up with the registered RAM output
      empty       <= empty_nxt;
      aempty      <= aempty_nxt;
    end
  end

  // the RAM reads the current slot at the accepting edge
  assign ram.rd_en   = rd_accept;
  assign ram.rd_addr = rd_ptr[ADDR_WIDTH-1:0];
  assign rd_data     = ram.rd_data;

endmodule

`default_nettype wire

// File: src/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo
  import afifo_pkg::*;
#(
  parameter int DATA_WIDTH  = AFIFO_DEF_DATA_W,
  parameter int FIFO_DEPTH  = AFIFO_DEF_DEPTH,   // power of two
  parameter int FIFO_AFULL  = FIFO_DEPTH-1,
  parameter int FIFO_AEMPTY = 1
) (
  input  wire                   wr_clk,
  input  wire                   wr_rst_n,
  input  wire                   wr_en,
  input  wire  [DATA_WIDTH-1:0] wr_data,
  input  wire                   rd_clk,
  input  wire                   rd_rst_n,
  input  wire                   rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_valid,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr_gray;
  logic [ADDR_WIDTH:0] wr_ptr_bin_rsync;
  logic [ADDR_WIDTH:0] rd_ptr_bin_wsync;

  afifo_ram_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram_if ();

  assign u_ram_if.wr_data = wr_data;

  afifo_dpram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_dpram (
    .wr_clk (wr_clk),
    .rd_clk (rd_clk),
    .ram    (u_ram_if.mem)
  );

  afifo_wr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .wr_en            (wr_en),
    .rd_ptr_bin_wsync (rd_ptr_bin_wsync),
    .ram              (u_ram_if.wr_side),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull)
  );

  afifo_rd_ctrl #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_bin_rsync (wr_ptr_bin_rsync),
    .ram              (u_ram_if.rd_side),
    .rd_ptr_gray      (rd_ptr_gray),
    .rd_data          (rd_data),
    .rd_valid         (rd_valid),
    .empty            (empty),
    .aempty           (aempty)
  );

  // write pointer into the read domain
  afifo_gray_sync #(
    .PTR_W (ADDR_WIDTH+1)
  ) u_wr2rd_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .ptr_gray  (wr_ptr_gray),
    .ptr_bin   (wr_ptr_bin_rsync)
  );

  // read pointer into the write domain
  afifo_gray_sync #(
    .PTR_W (ADDR_WIDTH+1)
  ) u_rd2wr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .ptr_gray  (rd_ptr_gray),
    .ptr_bin   (rd_ptr_bin_wsync)
  );

endmodule

`default_nettype wire

// File: verification/async_fifo_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_asserts (
  input wire wr_clk,
  input wire wr_rst_n,
  input wire full,
  input wire afull,
  input wire rd_clk,
  input wire rd_rst_n,
  input wire rd_en,
  input wire rd_valid,
  input wire empty,
  input wire aempty
);

  // a valid word only follows a read that was accepted one cycle earlier
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_valid |-> $past(rd_en && !empty))
    else $error("rd_valid without an accepted read in the previous cycle");

  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    full |-> afull)
    else $error("full is high while afull is low");

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    empty |-> aempty)
    else $error("empty is high while aempty is low");

endmodule

bind async_fifo async_fifo_asserts u_asserts (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .full     (full),
  .afull    (afull),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .rd_en    (rd_en),
  .rd_valid (rd_valid),
  .empty    (empty),
  .aempty   (aempty)
);

`default_nettype wire

// File: verification/tb_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_async_fifo;

  localparam int DATA_WIDTH     = 8;
  localparam int FIFO_DEPTH     = 16;
  localparam int FIFO_AFULL     = 12;
  localparam int FIFO_AEMPTY    = 2;
  localparam int RANDOM_WORDS   = 2000;
  localparam int IDLE_CYCLES    = 6;      // slow-clock cycles for the flags to settle
  localparam int TIMEOUT_CYCLES = 40000;  // read clock cycles
  localparam logic [31:0] SEED  = 32'h2e58_6979;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_valid;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  int                    write_index = 0;
  int                    read_index  = 0;
  int                    cycle_count = 0;
  integer                seed;
  logic [DATA_WIDTH-1:0] sentinel;

  async_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #4 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #6.5 wr_clk = ~wr_clk;
  end

  // nth payload, built from n alone so both sides agree without shared state
  function automatic logic [DATA_WIDTH-1:0] pattern(input int n);
    logic [31:0] u;
    logic [31:0] mix;
    u   = n;
    mix = {u[28:0], u[31:29]} ^ (u >> 11) ^ 32'h0000_00a5;
    return mix[DATA_WIDTH-1:0] ^ mix[2*DATA_WIDTH-1:DATA_WIDTH];
  endfunction

  // first value that none of the next FIFO_DEPTH payloads can take
  function automatic logic [DATA_WIDTH-1:0] choose_sentinel(input int base);
    logic hit;
    for (int cand = 0; cand < (1 << DATA_WIDTH); cand++) begin
      hit = 1'b0;
      for (int k = 0; k < FIFO_DEPTH; k++) begin
        if (pattern(base + k) == DATA_WIDTH'(cand)) hit = 1'b1;
      end
      if (!hit) return DATA_WIDTH'(cand);
    end
    return '0;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic wr_align();
    @(posedge wr_clk);
    #1;
  endtask

  task automatic rd_align();
    @(posedge rd_clk);
    #1;
  endtask

  // called 1 ns after a wr_clk edge, returns 1 ns after the next one
  task automatic write_cycle(input logic en, input logic [DATA_WIDTH-1:0] data,
                             output logic accepted);
    wr_en    = en;
    wr_data  = data;
    accepted = en && !full;  // full holds its value until the coming edge
    @(posedge wr_clk);
    #1;
  endtask

  task automatic read_cycle(input logic en);
    rd_en = en;
    @(posedge rd_clk);
    #1;
  endtask

  task automatic wait_idle();
    repeat (IDLE_CYCLES) @(posedge wr_clk);
  endtask

  task automatic run_random_traffic();
    logic        acc;
    logic [31:0] r_wr;
    logic [31:0] r_rd;
    fork
      begin
        wr_align();
        while (write_index < RANDOM_WORDS) begin
          r_wr = $random(seed);
          write_cycle(r_wr[0], pattern(write_index), acc);
          if (acc) write_index++;
        end
        wr_en = 1'b0;
      end
      begin
        rd_align();
        while (read_index < RANDOM_WORDS) begin
          r_rd = $random(seed);
          read_cycle(r_rd[2:0] < 3'd3);  // fewer reads per cycle, but the faster clock keeps up
        end
        rd_en = 1'b0;
      end
    join
  endtask

  task automatic fill_until_full();
    int                    base;
    logic                  acc;
    logic                  use_sentinel;
    logic [DATA_WIDTH-1:0] data;
    base     = write_index;
    sentinel = choose_sentinel(base);
    wr_align();
    for (int i = 0; i < 2 * FIFO_DEPTH + 8; i++) begin
      use_sentinel = (write_index - base >= FIFO_DEPTH);
      data         = use_sentinel ? sentinel : pattern(write_index);
      write_cycle(1'b1, data, acc);
      if (acc) begin
        assert (!use_sentinel)
          else stop_with_failure("A write was accepted while the FIFO was full");
        write_index++;
      end
    end
    wr_en = 1'b0;
    assert (write_index - base == FIFO_DEPTH)
      else stop_with_failure($sformatf("Mismatch at time %0t: %0d writes accepted, expected %0d",
                                       $time, write_index - base, FIFO_DEPTH));
    wait_idle();
    assert (full === 1'b1 && afull === 1'b1)
      else stop_with_failure($sformatf("Mismatch at time %0t: full %b afull %b after filling",
                                       $time, full, afull));
  endtask

  task automatic drain_to_empty();
    int start;
    start = read_index;
    rd_align();
    repeat (2 * FIFO_DEPTH + 8) read_cycle(1'b1);  // keeps reading well past empty
    rd_en = 1'b0;
    wait_idle();
    assert (read_index - start == FIFO_DEPTH)
      else stop_with_failure($sformatf("Mismatch at time %0t: %0d pops, expected %0d",
                                       $time, read_index - start, FIFO_DEPTH));
    assert (empty === 1'b1 && aempty === 1'b1 && full === 1'b0 && afull === 1'b0)
      else stop_with_failure($sformatf("Mismatch at time %0t: flags %b%b%b%b after draining",
                                       $time, empty, aempty, full, afull));
  endtask

  task automatic check_thresholds();
    int   count;
    logic acc;
    for (int k = 1; k <= FIFO_AFULL; k++) begin
      wr_align();
      write_cycle(1'b1, pattern(write_index), acc);
      wr_en = 1'b0;
      assert (acc)
        else stop_with_failure("A single write into a non-full FIFO was refused");
      write_index++;
      wait_idle();
      count = write_index - read_index;
      if (count == 2 || count == 3 || count == 11 || count == 12) begin
        assert (afull === (count >= FIFO_AFULL) && aempty === (count <= FIFO_AEMPTY))
          else stop_with_failure($sformatf("Mismatch at time %0t: count %0d afull %b aempty %b",
                                           $time, count, afull, aempty));
      end
    end
  endtask

  // compares every popped word with the reference, in order
  always @(negedge rd_clk) begin
    if (rd_rst_n && rd_valid) begin
      assert (rd_data === pattern(read_index))
        else stop_with_failure($sformatf("Mismatch at time %0t: word %0d expected %h, got %h",
                                         $time, read_index, pattern(read_index), rd_data));
      read_index = read_index + 1;
    end
  end

  always @(posedge rd_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure("Timeout: the test did not finish in the allowed read clock cycles");
    end
  end

  initial begin
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    sentinel = '0;
    seed     = SEED;
    fork
      begin
        repeat (2) @(posedge wr_clk);
        #1 wr_rst_n = 1'b1;
      end
      begin
        repeat (2) @(posedge rd_clk);
        #1 rd_rst_n = 1'b1;
      end
    join
    wait_idle();
    assert (empty === 1'b1 && aempty === 1'b1 && full === 1'b0 && afull === 1'b0 &&
            rd_valid === 1'b0)
      else stop_with_failure($sformatf("Mismatch at time %0t: reset flags %b%b%b%b valid %b",
                                       $time, empty, aempty, full, afull, rd_valid));
    run_random_traffic();
    wait_idle();
    fill_until_full();
    drain_to_empty();
    check_thresholds();
    rd_align();
    repeat (2 * FIFO_DEPTH) read_cycle(1'b1);
    rd_en = 1'b0;
    wait_idle();
    assert (read_index == write_index)
      else stop_with_failure("Not every accepted word was read back");
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/afifo_pkg.sv
src/afifo_ram_if.sv
src/afifo_dpram.sv
src/afifo_gray_sync.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/async_fifo.sv
verification/async_fifo_asserts.sv
verification/tb_async_fifo.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_async_fifo
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
